// ==== hdl/vcsr_pkg.sv ====
package vcsr_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN    = 32;   // scalar word
    localparam int VLEN    = 512;  // bits per vector register
    localparam int EW_W    = 7;    // element width field, up to 64
    localparam int MUL_W   = 4;    // lmul / emul field, up to 8
    localparam int VLMAX_W = 10;   // up to 512 elements

    ////////////////////////////////////////////////////////////
    // csr addresses and opcodes
    ////////////////////////////////////////////////////////////

    localparam logic [11:0] CSR_VSTART = 12'h008;
    localparam logic [11:0] CSR_VL     = 12'hC20;
    localparam logic [11:0] CSR_VTYPE  = 12'hC21;

    localparam logic [6:0]  OPC_SYSTEM = 7'h73;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0] xlen_t;

    // 4..7 reserved
    typedef enum logic [2:0] {
        SEW_8  = 3'd0,
        SEW_16 = 3'd1,
        SEW_32 = 3'd2,
        SEW_64 = 3'd3
    } vsew_e;

    // 4..7 reserved, no fractional lmul here
    typedef enum logic [2:0] {
        LMUL_1 = 3'd0,
        LMUL_2 = 3'd1,
        LMUL_4 = 3'd2,
        LMUL_8 = 3'd3
    } vlmul_e;

    typedef struct packed {
        logic   ill;
        logic   vma;    // mask agnostic
        logic   vta;    // tail agnostic
        vsew_e  vsew;
        vlmul_e vlmul;
    } vtype_t;

    // standard I-type layout of a Zicsr instruction
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;     // also uimm for the immediate forms
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_insn_t;

    typedef struct packed {
        logic [EW_W-1:0]    sew;
        logic [MUL_W-1:0]   lmul;
        logic [VLMAX_W-1:0] vlmax;
        logic               vta;
        logic               vma;
    } vcfg_t;

    typedef struct packed {
        logic [EW_W-1:0]    eew;
        logic [MUL_W-1:0]   emul;
        logic [VLMAX_W-1:0] e_vlmax;
    } mem_cfg_t;

endpackage

// ==== hdl/vcfg_regs.sv ====
`timescale 1ns/1ps

module vcfg_regs (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             csrwr_en,
    input  vcsr_pkg::xlen_t  scalar2,   // new vtype
    input  vcsr_pkg::xlen_t  scalar1,   // new vl
    output vcsr_pkg::vtype_t vtype,
    output vcsr_pkg::xlen_t  vl,
    output logic             csr_done
);
    import vcsr_pkg::*;

    logic csrwr_en_q;   // enable seen at the last edge
    logic cfg_wr;

    // one write per rising edge of the enable
    assign cfg_wr = csrwr_en && !csrwr_en_q;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            csrwr_en_q <= 1'b0;
        end else begin
            csrwr_en_q <= csrwr_en;
        end
    end

    ////////////////////////////////////////////////////////////
    // vtype / vl
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vtype    <= '{ill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: SEW_8, vlmul: LMUL_1};
            vl       <= '0;
            csr_done <= 1'b0;
        end else begin
            csr_done <= cfg_wr;   // high only the cycle after the edge
            if (cfg_wr) begin
                vtype.ill   <= 1'b0;
                vtype.vma   <= scalar2[7];
                vtype.vta   <= scalar2[6];
                vtype.vsew  <= vsew_e'(scalar2[5:3]);
                vtype.vlmul <= vlmul_e'(scalar2[2:0]);
                vl          <= scalar1;
            end
        end
    end

    // a held enable must not retrigger
    a_done_single: assert property (@(posedge clk) disable iff (!n_rst)
        csr_done |=> !csr_done);

endmodule

// ==== hdl/vtype_decode.sv ====
`timescale 1ns/1ps

module vtype_decode (
    input  vcsr_pkg::vtype_t vtype,
    output vcsr_pkg::vcfg_t  vcfg
);
    import vcsr_pkg::*;

    logic [1:0] sew_sh;    // log2(sew) - 3
    logic [1:0] lmul_sh;   // log2(lmul)
    logic       sew_ok;
    logic       lmul_ok;

    // reserved encodings have bit 2 set
    assign sew_ok  = !vtype.vsew[2];
    assign lmul_ok = !vtype.vlmul[2];

    always_comb begin
        sew_sh  = sew_ok  ? vtype.vsew[1:0]  : 2'd2;   // reserved sew acts as 32
        lmul_sh = lmul_ok ? vtype.vlmul[1:0] : 2'd0;

        vcfg.sew  = EW_W'(8 << sew_sh);
        vcfg.lmul = MUL_W'(1 << lmul_sh);

        // VLEN / sew * lmul, all powers of two
        if (lmul_ok) begin
            vcfg.vlmax = VLMAX_W'((VLEN >> (3'(sew_sh) + 3'd3)) << lmul_sh);
        end else begin
            vcfg.vlmax = VLMAX_W'(16);   // fixed for reserved lmul
        end

        vcfg.vta = vtype.vta;
        vcfg.vma = vtype.vma;
    end

endmodule

// ==== hdl/mem_emul_decode.sv ====
`timescale 1ns/1ps

module mem_emul_decode (
    input  logic [2:0]         width,   // funct3 width of a vector load/store
    input  vcsr_pkg::vcfg_t    vcfg,
    output vcsr_pkg::mem_cfg_t mcfg
);
    import vcsr_pkg::*;

    logic [1:0]        eew_sh;    // log2(eew) - 3
    logic [1:0]        sew_sh;    // log2(sew) - 3
    logic [1:0]        lmul_sh;   // log2(lmul)
    logic signed [3:0] emul_sh;   // -3 .. 6 before clamping
    logic [1:0]        emul_use;

    always_comb begin
        case (width)
            3'd0:    eew_sh = 2'd0;   // 8
            3'd5:    eew_sh = 2'd1;   // 16
            3'd6:    eew_sh = 2'd2;   // 32
            3'd7:    eew_sh = 2'd3;   // 64
            default: eew_sh = 2'd2;
        endcase

        // back from decoded values to exponents
        case (vcfg.sew)
            7'd8:    sew_sh = 2'd0;
            7'd16:   sew_sh = 2'd1;
            7'd64:   sew_sh = 2'd3;
            default: sew_sh = 2'd2;
        endcase

        case (vcfg.lmul)
            4'd2:    lmul_sh = 2'd1;
            4'd4:    lmul_sh = 2'd2;
            4'd8:    lmul_sh = 2'd3;
            default: lmul_sh = 2'd0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // emul = eew * lmul / sew
    ////////////////////////////////////////////////////////////

    always_comb begin
        emul_sh = $signed({2'b00, eew_sh}) + $signed({2'b00, lmul_sh})
                - $signed({2'b00, sew_sh});

        // fractional or above 8 falls back to 1
        if (emul_sh < 0 || emul_sh > 3) begin
            emul_use = 2'd0;
        end else begin
            emul_use = emul_sh[1:0];
        end

        mcfg.eew     = EW_W'(8 << eew_sh);
        mcfg.emul    = MUL_W'(1 << emul_use);
        mcfg.e_vlmax = VLMAX_W'((VLEN >> (3'(eew_sh) + 3'd3)) << emul_use);
    end

    // emul * sew == eew * lmul, unless the ratio had to be clamped to 1
    a_emul_legal: assert final (
        int'(mcfg.emul) * int'(vcfg.sew) == int'(mcfg.eew) * int'(vcfg.lmul)
        || (mcfg.emul == 4'd1
            && (int'(mcfg.eew) * int'(vcfg.lmul) < int'(vcfg.sew)
                || int'(mcfg.eew) * int'(vcfg.lmul) > 8 * int'(vcfg.sew))))
        else $error("emul %0d inconsistent with eew, lmul and sew", mcfg.emul);

endmodule

// ==== hdl/vstart_csr.sv ====
`timescale 1ns/1ps

module vstart_csr (
    input  logic                clk,
    input  logic                n_rst,
    input  vcsr_pkg::csr_insn_t inst,
    input  vcsr_pkg::xlen_t     scalar1,   // rs1 value or zero-extended uimm
    input  vcsr_pkg::vtype_t    vtype,
    input  vcsr_pkg::xlen_t     vl,
    output vcsr_pkg::xlen_t     csr_out,
    output vcsr_pkg::xlen_t     start_element
);
    import vcsr_pkg::*;

    xlen_t vstart_q;
    xlen_t vstart_d;
    xlen_t vtype_word;
    logic  is_system;
    logic  rd_only;   // set/clear form with rs1 = x0

    assign is_system = (inst.opcode == OPC_SYSTEM);
    assign rd_only   = inst.funct3[1] && (inst.rs1 == 5'd0);

    // architectural layout, ill in the msb
    assign vtype_word = {vtype.ill, 23'd0, vtype.vma, vtype.vta, vtype.vsew, vtype.vlmul};

    ////////////////////////////////////////////////////////////
    // decode and read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        vstart_d = '0;   // any other instruction clears vstart
        csr_out  = '0;
        if (is_system) begin
            case (inst.csr)
                CSR_VSTART: begin
                    // funct3[2] only picks reg vs imm, scalar1 already holds the operand
                    case (inst.funct3[1:0])
                        2'b01: begin   // csrrw / csrrwi
                            vstart_d = scalar1;
                            csr_out  = vstart_q;
                        end
                        2'b10: begin   // csrrs / csrrsi
                            vstart_d = vstart_q | scalar1;
                            csr_out  = vstart_q;
                        end
                        2'b11: begin   // csrrc / csrrci
                            vstart_d = vstart_q & ~scalar1;
                            csr_out  = vstart_q;
                        end
                        default: ;
                    endcase
                end
                CSR_VTYPE: begin
                    if (rd_only) csr_out = vtype_word;
                end
                CSR_VL: begin
                    if (rd_only) csr_out = vl;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vstart_q <= '0;
        end else begin
            vstart_q <= vstart_d;
        end
    end

    assign start_element = vstart_q;

    a_out_quiet: assert property (@(posedge clk) disable iff (!n_rst)
        !is_system |-> (csr_out == '0));

endmodule

// ==== hdl/vec_csr_top.sv ====
`timescale 1ns/1ps

module vec_csr_top (
    input  logic                clk,
    input  logic                n_rst,
    input  vcsr_pkg::csr_insn_t inst,
    input  vcsr_pkg::xlen_t     scalar1,
    input  vcsr_pkg::xlen_t     scalar2,
    input  logic [2:0]          width,
    input  logic                csrwr_en,
    output vcsr_pkg::xlen_t     csr_out,
    output vcsr_pkg::xlen_t     vec_length,
    output vcsr_pkg::xlen_t     start_element,
    output vcsr_pkg::vcfg_t     vcfg,
    output vcsr_pkg::mem_cfg_t  mcfg,
    output logic                csr_done
);
    import vcsr_pkg::*;

    vtype_t vtype;   // stored config, shared by decode and read mux

    vcfg_regs u_cfg (
        .clk      (clk),
        .n_rst    (n_rst),
        .csrwr_en (csrwr_en),
        .scalar2  (scalar2),
        .scalar1  (scalar1),
        .vtype    (vtype),
        .vl       (vec_length),
        .csr_done (csr_done)
    );

    vtype_decode u_vtype_dec (
        .vtype (vtype),
        .vcfg  (vcfg)
    );

    mem_emul_decode u_mem_dec (
        .width (width),
        .vcfg  (vcfg),
        .mcfg  (mcfg)
    );

    vstart_csr u_vstart (
        .clk           (clk),
        .n_rst         (n_rst),
        .inst          (inst),
        .scalar1       (scalar1),
        .vtype         (vtype),
        .vl            (vec_length),
        .csr_out       (csr_out),
        .start_element (start_element)
    );

endmodule

// ==== sim/vec_csr_tb.sv ====
`timescale 1ns/1ps

module vec_csr_tb;
    import vcsr_pkg::*;

    typedef struct packed {
        logic [7:0] kind;   // C config, M memory decode, I instruction
        xlen_t      a;
        xlen_t      b;
        xlen_t      c;
        xlen_t      d;
        xlen_t      e;
        xlen_t      f;
    } step_t;

    localparam xlen_t NOP_INSN   = 32'h0000_0013;   // addi x0, x0, 0
    localparam xlen_t READ_VTYPE = 32'hC210_20F3;   // csrrs x1, vtype, x0

    logic       clk;
    logic       n_rst;
    csr_insn_t  inst;
    xlen_t      scalar1;
    xlen_t      scalar2;
    logic [2:0] width;
    logic       csrwr_en;

    xlen_t      csr_out;
    xlen_t      vec_length;
    xlen_t      start_element;
    vcfg_t      vcfg;
    mem_cfg_t   mcfg;
    logic       csr_done;

    step_t       steps[$];
    int          step_no;
    int unsigned cycles;
    int unsigned limit = 50;

    vec_csr_top dut0 (
        .clk           (clk),
        .n_rst         (n_rst),
        .inst          (inst),
        .scalar1       (scalar1),
        .scalar2       (scalar2),
        .width         (width),
        .csrwr_en      (csrwr_en),
        .csr_out       (csr_out),
        .vec_length    (vec_length),
        .start_element (start_element),
        .vcfg          (vcfg),
        .mcfg          (mcfg),
        .csr_done      (csr_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog, limit set once the stimulus is loaded
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > limit) begin
                abort_run($sformatf("run timed out after %0d cycles", cycles));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reporting and compares
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run($sformatf("mismatch at stimulus step %0d", step_no));
        end
    endtask

    task automatic check_vcfg(input vcfg_t got, input vcfg_t exp);
        if (got !== exp) begin
            $display("[ERROR] vcfg got 0x%h expected 0x%h", got, exp);
            abort_run($sformatf("mismatch at stimulus step %0d", step_no));
        end
    endtask

    task automatic check_mcfg(input mem_cfg_t got, input mem_cfg_t exp);
        if (got !== exp) begin
            $display("[ERROR] mcfg got 0x%h expected 0x%h", got, exp);
            abort_run($sformatf("mismatch at stimulus step %0d", step_no));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus file
    ////////////////////////////////////////////////////////////

    task automatic load_steps;
        int              fd;
        int              code;
        int              want;
        logic [7:0]      ch;
        xlen_t           a, b, c, d, e, f;
        logic [8*200-1:0] rest;   // tail of a comment line
        step_t           s;
        fd = $fopen("sim/vec_csr_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("could not open sim/vec_csr_stimulus.txt");
        end
        code = $fscanf(fd, " %c", ch);
        while (code == 1) begin
            if (ch == "#") begin
                code = $fgets(rest, fd);
            end else begin
                e = '0;
                f = '0;
                if (ch == "C") begin
                    want = 6;
                    code = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
                end else if (ch == "M" || ch == "I") begin
                    want = 4;
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                end else begin
                    abort_run($sformatf("unknown step kind '%c' in stimulus file", ch));
                end
                if (code != want) begin
                    abort_run($sformatf("malformed stimulus line after step %0d", steps.size()));
                end
                s = '{kind: ch, a: a, b: b, c: c, d: d, e: e, f: f};
                steps.push_back(s);
            end
            code = $fscanf(fd, " %c", ch);
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // step kinds
    ////////////////////////////////////////////////////////////

    task automatic run_cfg(input step_t s);
        vcfg_t exp_cfg;
        exp_cfg.sew   = s.c[EW_W-1:0];
        exp_cfg.lmul  = s.d[MUL_W-1:0];
        exp_cfg.vlmax = s.e[VLMAX_W-1:0];
        exp_cfg.vta   = s.a[6];   // tail and mask bits pass straight through
        exp_cfg.vma   = s.a[7];
        @(posedge clk);
        inst     <= csr_insn_t'(NOP_INSN);
        scalar2  <= s.a;
        scalar1  <= s.b;
        csrwr_en <= 1'b1;
        @(negedge clk);
        while (!csr_done) @(negedge clk);
        check_vcfg(vcfg, exp_cfg);
        check_word("vec_length", vec_length, s.b);
        // enable stays high, done must not come back
        repeat (2) begin
            @(negedge clk);
            check_word("csr_done", xlen_t'(csr_done), '0);
        end
        @(posedge clk);
        csrwr_en <= 1'b0;
        scalar1  <= '0;
        inst     <= csr_insn_t'(READ_VTYPE);
        @(negedge clk);
        check_word("csr_out", csr_out, s.f);   // packed vtype read-back
    endtask

    task automatic run_mem(input step_t s);
        mem_cfg_t exp_mem;
        exp_mem.eew     = s.b[EW_W-1:0];
        exp_mem.emul    = s.c[MUL_W-1:0];
        exp_mem.e_vlmax = s.d[VLMAX_W-1:0];
        @(posedge clk);
        inst  <= csr_insn_t'(NOP_INSN);
        width <= s.a[2:0];
        @(negedge clk);
        check_mcfg(mcfg, exp_mem);
    endtask

    // one instruction per cycle, vstart shown is from the previous instruction
    task automatic run_insn(input step_t s);
        @(posedge clk);
        inst    <= csr_insn_t'(s.a);
        scalar1 <= s.b;
        @(negedge clk);
        check_word("csr_out", csr_out, s.c);
        check_word("start_element", start_element, s.d);
    endtask

    initial begin
        n_rst    = 1'b0;
        inst     = csr_insn_t'(NOP_INSN);
        scalar1  = '0;
        scalar2  = '0;
        width    = 3'd0;
        csrwr_en = 1'b0;
        step_no  = 0;
        load_steps();
        limit = 8 * steps.size() + 50;
        repeat (4) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        check_word("vec_length", vec_length, '0);
        check_word("start_element", start_element, '0);
        check_word("csr_done", xlen_t'(csr_done), '0);
        for (step_no = 0; step_no < steps.size(); step_no++) begin
            case (steps[step_no].kind)
                "C":     run_cfg(steps[step_no]);
                "M":     run_mem(steps[step_no]);
                default: run_insn(steps[step_no]);
            endcase
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== vec_csr_top.f ====
hdl/vcsr_pkg.sv
hdl/vcfg_regs.sv
hdl/vtype_decode.sv
hdl/mem_emul_decode.sv
hdl/vstart_csr.sv
hdl/vec_csr_top.sv
sim/vec_csr_tb.sv

// ==== sim/vec_csr_stimulus.txt ====
# C: scalar2 scalar1 sew lmul vlmax vtype_read   M: width eew emul e_vlmax
# I: inst scalar1 csr_out start_element          all values hex
I C21020F3 00000000 80000000 00000000
I C20020F3 00000000 00000000 00000000
C 00000040 00000040 8 1 40 40
C 00000089 00000020 10 2 40 89
M 0 8 1 40
M 1 20 4 40
M 2 20 4 40
M 3 20 4 40
M 4 20 4 40
M 5 10 2 40
M 6 20 4 40
M 7 40 8 40
C 00000013 00000080 20 8 80 13
C 000000DA 00000011 40 4 20 DA
# reserved sew and lmul
C 00000025 00000010 20 1 10 25
M 7 40 2 10
M 5 10 1 20
C 0000006C 0000000F 20 1 10 6C
C 00000037 00000003 20 1 10 37
C 000000BE 00000001 20 1 10 BE
C 00000031 00000020 20 2 20 31
C ABCD0003 00000200 8 8 200 03
M 0 8 8 200
M 7 40 1 8
C 00000018 00000008 40 1 8 18
M 0 8 1 40
M 6 20 1 10
# vstart forms, then reads and non-vstart cycles
I 008290F3 0000005A 00000000 00000000
I 0082A0F3 00000101 0000005A 0000005A
I 0082B0F3 0000000F 0000015B 0000015B
I 0081D0F3 00000003 00000150 00000150
I 008260F3 00000004 00000003 00000003
I 0080F0F3 00000001 00000007 00000007
I C20020F3 00000000 00000008 00000006
I 008290F3 00000077 00000000 00000000
I C21020F3 00000000 00000018 00000077
I 008290F3 00000033 00000000 00000000
I C212A0F3 00000000 00000000 00000033
I 008290F3 00000044 00000000 00000000
I 008290B3 00000044 00000000 00000044
I C20010F3 00000000 00000000 00000000
I C20060F3 00000000 00000008 00000000
I 00000013 00000000 00000000 00000000
